/* verilog.f */
+incdir+.
sample_pkg.sv
ctrl_pkg.sv
carrier_if.sv
carrier_filter.sv
lifo_bank.sv
pingpong_stack.sv
ofdm_demap_top.sv
tb_ofdm_demap.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the demapper testbench with verilator, run it, judge by the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -f verilog.f --top-module tb_ofdm_demap \
	-o tb_sim > "$BUILD_LOG" 2>&1 \
	|| { echo "build failed, see $BUILD_LOG"; exit 1; }

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "^TEST OK$" "$SIM_LOG" && echo "simulation passed" \
	|| { echo "simulation failed, see $SIM_LOG"; exit 1; }

/* tb_ofdm_demap.sv */
`include "ofdm_defs.svh"

module tb_ofdm_demap;
	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {
		MODE_NOW,   // credit back on the cycle after each sample
		MODE_GAP,   // credit back after a random gap
		MODE_HOLD   // no credits go back
	} credit_mode_t;

	typedef struct packed {
		int           n_sym;  // symbols sent in this row
		credit_mode_t mode;
		logic         ovf;    // overflow expected at the end of the row
	} row_t;

	localparam int ROWS        = 3;
	localparam int IDLE_CYCLES = 48;  // quiet cycles between symbols so a bank can drain

	logic                 clk;
	logic                 reset;
	logic                 in_valid;
	sample_pkg::bin_idx_t in_bin;
	sample_pkg::sample_t  in_re;
	sample_pkg::sample_t  in_im;
	logic                 credit_return;
	logic                 out_valid;
	sample_pkg::sample_t  out_re;
	sample_pkg::sample_t  out_im;
	logic                 out_last;
	logic                 overflow;

	row_t         stim_table [ROWS];
	credit_mode_t return_mode;
	logic [24:0]  exp_q [$];      // {last, re, im} in output order
	int           rd_idx;         // next expected entry, moved by the monitor
	int           model_credits;  // credits the DUT should still hold
	int           consumed_cnt;   // samples taken downstream
	int           returned_cnt;   // credit pulses sent back
	int           mon_mismatch;
	int           mon_fail;
	int           chk_mismatch;
	int           cycle_cnt;
	int           timeout_limit;
	bit           timed_out;

	ofdm_demap_top dut0
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_bin(in_bin),
		.in_re(in_re),
		.in_im(in_im),
		.credit_return(credit_return),
		.out_valid(out_valid),
		.out_re(out_re),
		.out_im(out_im),
		.out_last(out_last),
		.overflow(overflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;  // 4 ns period
	end

	// ====================
	// sample and bin rules
	// ====================
	function automatic logic [11:0] bin_word(input int sym, input int b);
		logic [5:0] hi;
		logic [5:0] lo;
		hi = sym[5:0];  // symbol number on top
		lo = b[5:0];    // bin below
		return {hi, lo};
	endfunction

	function automatic bit is_data_bin(input int b);
		if (b == `OFDM_PILOT_0 || b == `OFDM_PILOT_1 || b == `OFDM_PILOT_2 || b == `OFDM_PILOT_3)
			return 1'b0;
		if (b >= `OFDM_NULL_LO && b <= `OFDM_NULL_HI)
			return 1'b0;
		return b != `OFDM_LAST_BIN;
	endfunction

	// stack reverses the symbol so the bins are walked from the top down
	task automatic queue_symbol(input int sym);
		int          b;
		int          n;
		logic [11:0] word;
		n = 0;
		for (b = `OFDM_BINS - 1; b >= 0; b--)
		begin
			if (is_data_bin(b))
			begin
				n++;
				word = bin_word(sym, b);
				exp_q.push_back({n == `OFDM_DATA_CARRIERS, word, ~word});  // last on bin 0
			end
		end
	endtask

	task automatic send_symbol(input int sym);
		int b;
		for (b = 0; b < `OFDM_BINS; b++)
		begin
			@(posedge clk);
			#1;
			in_valid = 1'b1;
			in_bin   = sample_pkg::bin_idx_t'(b);
			in_re    = bin_word(sym, b);
			in_im    = ~bin_word(sym, b);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic finish_run();
		int bad;
		bad = mon_mismatch + chk_mismatch + mon_fail + int'(timed_out);
		$display("errors: %0d mismatches, %0d other failures, %0d samples checked",
			mon_mismatch + chk_mismatch, mon_fail + int'(timed_out), rd_idx);
		if (bad == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	// ====================
	// downstream credit model
	// ====================
	initial
	begin
		int unsigned gap_left;
		gap_left      = 0;
		credit_return = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			credit_return = 1'b0;
			if (consumed_cnt > returned_cnt && return_mode != MODE_HOLD)
			begin
				if (return_mode == MODE_GAP && gap_left != 0)
					gap_left--;                       // still waiting
				else
				begin
					credit_return = 1'b1;             // hand one credit back
					returned_cnt++;
					if (return_mode == MODE_GAP)
						gap_left = $urandom_range(1, 0);
				end
			end
		end
	end

	// outputs settle at the rising edge and are read half a cycle later
	always @(negedge clk)
	begin : monitor
		logic [24:0] exp_word;
		if (!reset)
			model_credits = `OFDM_OUT_CREDITS;
		else
		begin
			if (out_valid)
			begin
				if (model_credits == 0)
				begin
					mon_fail++;
					$display("credit error: sample %0d presented with no credit held", rd_idx);
				end
				else
					model_credits--;
				consumed_cnt++;
				if (rd_idx >= exp_q.size())
				begin
					mon_fail++;
					$display("unexpected output sample re %h im %h", out_re, out_im);
				end
				else
				begin
					exp_word = exp_q[rd_idx];
					rd_idx++;
					if (out_re !== exp_word[23:12])
					begin
						mon_mismatch++;
						$display("MISMATCH out_re: got %h expected %h", out_re, exp_word[23:12]);
					end
					if (out_im !== exp_word[11:0])
					begin
						mon_mismatch++;
						$display("MISMATCH out_im: got %h expected %h", out_im, exp_word[11:0]);
					end
					if (out_last !== exp_word[24])
					begin
						mon_mismatch++;
						$display("MISMATCH out_last: got %h expected %h", out_last, exp_word[24]);
					end
				end
			end
			if (credit_return)
				model_credits++;  // lands in the DUT at the next edge
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_limit)
		begin
			timed_out = 1'b1;
			$display("timeout: run stopped after %0d cycles, %0d samples never arrived",
				cycle_cnt, exp_q.size() - rd_idx);
			finish_run();
		end
	end

	// ====================
	// main sequence
	// ====================
	initial
	begin
		int r;
		int s;
		int sym_no;
		int total;
		void'($urandom(32'h6b2a));
		reset         = 1'b0;
		in_valid      = 1'b0;
		in_bin        = '0;
		in_re         = '0;
		in_im         = '0;
		return_mode   = MODE_NOW;
		stim_table[0] = '{2, MODE_NOW, 1'b0};   // plain throughput
		stim_table[1] = '{3, MODE_GAP, 1'b0};   // slow downstream that the banks absorb
		stim_table[2] = '{3, MODE_HOLD, 1'b1};  // stalled downstream loses the third symbol
		total = 0;
		for (r = 0; r < ROWS; r++)
			total += stim_table[r].n_sym;
		timeout_limit = 200 * total + 100;
		sym_no        = 0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b1;
		repeat (10)
		begin
			@(negedge clk);
			if (out_valid !== 1'b0)
			begin
				chk_mismatch++;
				$display("MISMATCH out_valid after reset: got %h expected 0", out_valid);
			end
			if (overflow !== 1'b0)
			begin
				chk_mismatch++;
				$display("MISMATCH overflow after reset: got %h expected 0", overflow);
			end
		end
		for (r = 0; r < ROWS; r++)
		begin
			@(negedge clk);
			return_mode = stim_table[r].mode;
			for (s = 0; s < stim_table[r].n_sym; s++)
			begin
				// with credits held only the symbols that reach the two banks survive
				if (stim_table[r].mode != MODE_HOLD || s < 2)
					queue_symbol(sym_no);
				send_symbol(sym_no);
				repeat (IDLE_CYCLES) @(posedge clk);
				sym_no++;
			end
			@(negedge clk);
			return_mode = MODE_NOW;  // downstream catches up
			while (rd_idx != exp_q.size())
				@(posedge clk);
			repeat (20) @(posedge clk);  // room for a stray sample to show up
			@(negedge clk);
			if (overflow !== stim_table[r].ovf)
			begin
				chk_mismatch++;
				$display("MISMATCH overflow row %0d: got %h expected %h", r, overflow,
					stim_table[r].ovf);
			end
		end
		finish_run();
	end

endmodule

/* ofdm_demap_top.sv */
`include "ofdm_defs.svh"

module ofdm_demap_top
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  sample_pkg::bin_idx_t in_bin,
	input  sample_pkg::sample_t  in_re,
	input  sample_pkg::sample_t  in_im,
	input  logic                 credit_return,
	output logic                 out_valid,
	output sample_pkg::sample_t  out_re,
	output sample_pkg::sample_t  out_im,
	output logic                 out_last,
	output logic                 overflow
);

	logic                pop_valid;  // stack presents a sample
	sample_pkg::sample_t pop_re;
	sample_pkg::sample_t pop_im;
	logic                pop_last;   // 48th carrier of a symbol

	carrier_if carrier ();  // filter to stack link

	carrier_filter u_filter
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_bin(in_bin),
		.in_re(in_re),
		.in_im(in_im),
		.out(carrier.source)
	);

	pingpong_stack u_stack
	(
		.clk(clk),
		.reset(reset),
		.in(carrier.sink),
		.credit_return(credit_return),
		.pop_valid(pop_valid),
		.pop_re(pop_re),
		.pop_im(pop_im),
		.pop_last(pop_last),
		.overflow(overflow)
	);

	// ====================
	// output register
	// ====================
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end
		else
		begin
			out_valid <= pop_valid;              // one cycle per sample
			out_last  <= pop_last;
		end
	end

	always_ff @(posedge clk)
	begin
		out_re <= pop_re;                      // qualified by out_valid
		out_im <= pop_im;
	end

endmodule

/* pingpong_stack.sv */
`include "ofdm_defs.svh"

module pingpong_stack
(
	input  logic                clk,
	input  logic                reset,
	carrier_if.sink             in,
	input  logic                credit_return,
	output logic                pop_valid,
	output sample_pkg::sample_t pop_re,
	output sample_pkg::sample_t pop_im,
	output logic                pop_last,
	output logic                overflow
);

	ctrl_pkg::bank_state_t    state [2];      // index 0 is bank a
	ctrl_pkg::bank_state_t    state_nxt [2];
	logic                     fill_sel;       // bank taking the current symbol
	logic                     drain_sel;      // bank feeding the output
	logic                     drop;           // current symbol is being discarded
	ctrl_pkg::credit_t        credits;        // samples we may still present
	logic [1:0]               push;
	logic [1:0]               pop;
	sample_pkg::sample_t      top_re [2];
	sample_pkg::sample_t      top_im [2];
	sample_pkg::carrier_cnt_t count [2];
	logic                     fill_ok;        // target bank accepts carriers
	logic                     seal;           // target bank closes this cycle
	logic                     retarget;       // pick the bank for the next symbol
	logic                     next_sel;
	logic                     next_ok;        // some bank is free for it
	logic                     draining;
	logic                     drain_done;     // 48th pop this cycle
	logic                     drain_go;       // a full bank starts to drain
	logic                     drain_pick;
	logic [1:0]               bank_free;

	lifo_bank bank_a
	(
		.clk(clk),
		.reset(reset),
		.push(push[0]),
		.pop(pop[0]),
		.push_re(in.re),
		.push_im(in.im),
		.pop_re(top_re[0]),
		.pop_im(top_im[0]),
		.count(count[0])
	);

	lifo_bank bank_b
	(
		.clk(clk),
		.reset(reset),
		.push(push[1]),
		.pop(pop[1]),
		.push_re(in.re),
		.push_im(in.im),
		.pop_re(top_re[1]),
		.pop_im(top_im[1]),
		.count(count[1])
	);

	// ====================
	// read side
	// ====================
	assign draining   = (state[drain_sel] == ctrl_pkg::BANK_DRAIN);
	assign pop_valid  = draining && (credits != '0);  // one pop per held credit
	assign pop        = {pop_valid && drain_sel, pop_valid && !drain_sel};
	assign pop_re     = top_re[drain_sel];
	assign pop_im     = top_im[drain_sel];
	assign pop_last   = pop_valid && (count[drain_sel] == sample_pkg::carrier_cnt_t'(1));
	assign drain_done = pop_last;
	// alternate banks so the older symbol drains first
	assign drain_pick = (state[~drain_sel] == ctrl_pkg::BANK_FULL) ? ~drain_sel : drain_sel;
	assign drain_go   = !draining && (state[drain_pick] == ctrl_pkg::BANK_FULL);

	// ====================
	// write side
	// ====================
	assign bank_free[0] = (state[0] == ctrl_pkg::BANK_EMPTY) || (drain_done && !drain_sel);
	assign bank_free[1] = (state[1] == ctrl_pkg::BANK_EMPTY) || (drain_done && drain_sel);
	assign fill_ok  = !drop && ((state[fill_sel] == ctrl_pkg::BANK_EMPTY) ||
		(state[fill_sel] == ctrl_pkg::BANK_FILL));
	assign push     = {in.valid && fill_ok && fill_sel, in.valid && fill_ok && !fill_sel};
	assign seal     = in.sym_end && fill_ok &&
		(push[fill_sel] || (state[fill_sel] == ctrl_pkg::BANK_FILL));
	assign retarget = in.sym_end && (drop || seal);  // symbol boundary decision

	always_comb
	begin
		next_sel = ~fill_sel;                // the other bank takes the next symbol
		next_ok  = bank_free[~fill_sel];
	end

	always_comb
	begin
		state_nxt = state;
		if (drain_done)
			state_nxt[drain_sel] = ctrl_pkg::BANK_EMPTY;
		else if (drain_go)
			state_nxt[drain_pick] = ctrl_pkg::BANK_DRAIN;
		// write side last so a bank freed this cycle may be refilled at once
		if (push[0])
			state_nxt[0] = ctrl_pkg::BANK_FILL;
		if (push[1])
			state_nxt[1] = ctrl_pkg::BANK_FILL;
		if (seal)
			state_nxt[fill_sel] = ctrl_pkg::BANK_FULL;
		if (retarget && next_ok)
			state_nxt[next_sel] = ctrl_pkg::BANK_FILL;
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			state[0]  <= ctrl_pkg::BANK_EMPTY;
			state[1]  <= ctrl_pkg::BANK_EMPTY;
			fill_sel  <= 1'b0;  // bank a fills first
			drain_sel <= 1'b0;
			drop      <= 1'b0;
			overflow  <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (retarget)
			begin
				if (next_ok)
					fill_sel <= next_sel;
				drop <= !next_ok;      // both banks busy so the next symbol is lost
				if (!next_ok)
					overflow <= 1'b1;    // sticky until reset
			end
			if (drain_go)
				drain_sel <= drain_pick;
		end
	end

	// ====================
	// output credits
	// ====================
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			credits <= ctrl_pkg::credit_t'(`OFDM_OUT_CREDITS);
		else
		begin
			case ({credit_return, pop_valid})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;  // spend and return cancel
			endcase
		end
	end

	// downstream never hands back more than it was given
	a_credit_bound: assert property (
		@(posedge clk) disable iff (!reset)
		credits <= `OFDM_OUT_CREDITS
	) else $error("pingpong_stack: credit count %0d above limit", credits);

endmodule

/* lifo_bank.sv */
`include "ofdm_defs.svh"

module lifo_bank
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     push,
	input  logic                     pop,
	input  sample_pkg::sample_t      push_re,
	input  sample_pkg::sample_t      push_im,
	output sample_pkg::sample_t      pop_re,
	output sample_pkg::sample_t      pop_im,
	output sample_pkg::carrier_cnt_t count
);

	localparam int DEPTH = `OFDM_DATA_CARRIERS;  // one symbol worth of carriers

	sample_pkg::sample_t      mem_re [DEPTH];  // I words
	sample_pkg::sample_t      mem_im [DEPTH];  // Q words
	sample_pkg::carrier_cnt_t top_idx;         // slot of the newest entry

	// count doubles as the stack pointer, top sits one below it
	assign top_idx = (count == '0) ? '0 : count - 1'b1;
	assign pop_re  = mem_re[top_idx];  // top visible without a pop
	assign pop_im  = mem_im[top_idx];

	always_ff @(posedge clk)
	begin
		if (push && pop)
		begin
			mem_re[top_idx] <= push_re;  // swap the top in place
			mem_im[top_idx] <= push_im;
		end
		else if (push)
		begin
			mem_re[count] <= push_re;    // first free slot
			mem_im[count] <= push_im;
		end
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
			count <= '0;
		else
		begin
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or swap
			endcase
		end
	end

	// the controller seals a bank at 48, a 49th push would mean lost framing
	a_no_overflow: assert property (
		@(posedge clk) disable iff (!reset)
		(push && !pop) |-> (count < DEPTH)
	) else $error("lifo_bank: push into full stack");

	a_no_underflow: assert property (
		@(posedge clk) disable iff (!reset)
		pop |-> (count != '0)
	) else $error("lifo_bank: pop from empty stack");

endmodule

/* carrier_filter.sv */
`include "ofdm_defs.svh"

module carrier_filter
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_valid,
	input  sample_pkg::bin_idx_t in_bin,
	input  sample_pkg::sample_t  in_re,
	input  sample_pkg::sample_t  in_im,
	carrier_if.source            out
);

	logic                 is_pilot;  // one of the four pilot bins
	logic                 is_null;   // inside the null band
	logic                 is_last;   // bin 63
	logic                 is_data;   // carrier that goes on to the stack
	sample_pkg::bin_idx_t exp_bin;   // bin expected on the next valid beat

	// ====================
	// bin classification
	// ====================
	always_comb
	begin
		is_pilot = (in_bin == `OFDM_PILOT_0) || (in_bin == `OFDM_PILOT_1) ||
			(in_bin == `OFDM_PILOT_2) || (in_bin == `OFDM_PILOT_3);
		is_null  = (in_bin >= `OFDM_NULL_LO) && (in_bin <= `OFDM_NULL_HI);  // 11 bins
		is_last  = (in_bin == `OFDM_LAST_BIN);
		is_data  = !(is_pilot || is_null || is_last);                     // 48 of 64 left
	end

	// ====================
	// one register stage
	// ====================
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			out.valid   <= 1'b0;
			out.sym_end <= 1'b0;
			exp_bin     <= '0;  // symbols start at bin 0
		end
		else
		begin
			out.valid   <= in_valid && is_data;  // pilots, nulls and bin 63 vanish here
			out.sym_end <= in_valid && is_last;  // arrives with valid clear
			if (in_valid)
				exp_bin <= in_bin + 1'b1;          // wraps 63 -> 0
		end
	end

	// payload only moves on a data bin
	always_ff @(posedge clk)
	begin
		if (in_valid && is_data)
		begin
			out.re <= in_re;
			out.im <= in_im;
		end
	end

	// fft delivers every bin of a symbol in natural order, gaps allowed
	a_bin_order: assert property (
		@(posedge clk) disable iff (!reset)
		in_valid |-> (in_bin == exp_bin)
	) else $error("carrier_filter: bin %0d out of order, expected %0d", in_bin, exp_bin);

endmodule

/* carrier_if.sv */
`include "ofdm_defs.svh"

// one data carrier per beat from the filter to the stack
// no ready line, the fft side cannot stall
interface carrier_if;

	logic                valid;    // beat holds a data carrier
	sample_pkg::sample_t re;       // in-phase
	sample_pkg::sample_t im;       // quadrature
	logic                sym_end;  // beat closes the symbol

	modport source
	(
		output valid,
		output re,
		output im,
		output sym_end
	);

	modport sink
	(
		input valid,
		input re,
		input im,
		input sym_end
	);

endinterface

/* ctrl_pkg.sv */
`include "ofdm_defs.svh"

package ctrl_pkg;

	typedef enum logic [1:0] {
		BANK_EMPTY,   // free, may be picked for the next symbol
		BANK_FILL,    // taking carriers of the current symbol
		BANK_FULL,    // whole symbol stored, waiting for the read side
		BANK_DRAIN    // popping toward the output
	} bank_state_t;

	typedef logic [$clog2(`OFDM_OUT_CREDITS+1)-1:0] credit_t;  // 0 to 4 credits

endpackage

/* sample_pkg.sv */
`include "ofdm_defs.svh"

package sample_pkg;

	// one I or Q word from the fft
	typedef logic signed [`OFDM_SAMPLE_W-1:0] sample_t;

	typedef logic [$clog2(`OFDM_BINS)-1:0] bin_idx_t;                 // fft bin number

	// 0 to 48 carriers held in one stack
	typedef logic [$clog2(`OFDM_DATA_CARRIERS+1)-1:0] carrier_cnt_t;

endpackage

/* ofdm_defs.svh */
`ifndef OFDM_DEFS_SVH
`define OFDM_DEFS_SVH

// ====================
// sample and symbol geometry
// ====================
`define OFDM_SAMPLE_W       12  // width of one I or Q word
`define OFDM_BINS           64  // fft bins per symbol
`define OFDM_DATA_CARRIERS  48  // carriers kept per symbol, sets stack depth
`define OFDM_OUT_CREDITS    4   // credits held by the stack after reset

// ====================
// bin map
// ====================
`define OFDM_PILOT_0        6   // pilot positions, dropped
`define OFDM_PILOT_1        20
`define OFDM_PILOT_2        42
`define OFDM_PILOT_3        56
`define OFDM_NULL_LO        26  // null band, inclusive on both ends
`define OFDM_NULL_HI        36
`define OFDM_LAST_BIN       63  // dropped, closes the symbol

`endif
